// File: bench/ecc_store_sva.sv
// ECC store assertions

`timescale 1ns/1ps

module ecc_store_sva (
   input logic                clk,
   input logic                rst_l,
   input logic                rd_single_err,
   input logic                rd_double_err,
   input logic                wr_en,
   input logic                scrub_wr,
   input ecc_pkg::fix_count_t scrub_fix_count
);

   // a read is either clean, single or double, never two at once
   flags_exclusive: assert property (@(posedge clk) disable iff (!rst_l)
      !(rd_single_err && rd_double_err))
      else $error("read reported single and double error in the same cycle");

   no_write_clash: assert property (@(posedge clk) disable iff (!rst_l)
      !(scrub_wr && wr_en))
      else $error("scrub write issued while a user write was active");

   count_never_drops: assert property (@(posedge clk) disable iff (!rst_l)
      scrub_fix_count >= $past(scrub_fix_count))   // saturates, never wraps
      else $error("scrub fix count went down");

endmodule

bind ecc_store_top ecc_store_sva sva_i (
   .clk             (clk),
   .rst_l           (rst_l),
   .rd_single_err   (rd_single_err),
   .rd_double_err   (rd_double_err),
   .wr_en           (wr_en),
   .scrub_wr        (scrub_wr),
   .scrub_fix_count (scrub_fix_count)
);

// File: bench/ecc_store_tb.sv
// ECC store testbench

`timescale 1ns/1ps

module ecc_store_tb;

   localparam int DRIVE_DLY     = 10;     // ns after the rising edge
   localparam int SCRUB_TIMEOUT = 2000;   // cycles
   localparam int BUSY_TIMEOUT  = 100;

   typedef enum logic [1:0] {op_write, op_read, op_rdwr} op_t;

   typedef struct packed {
      op_t            op;
      ecc_pkg::addr_t addr;
      ecc_pkg::data_t data;
      ecc_pkg::code_t mask;
      ecc_pkg::data_t exp_data;
      logic           exp_single;
      logic           exp_double;
   } entry_t;

   logic                clk;
   logic                rst_l;
   logic                wr_en;
   ecc_pkg::addr_t      wr_addr;
   ecc_pkg::data_t      wr_data;
   ecc_pkg::code_t      inj_mask;
   logic                rd_en;
   ecc_pkg::addr_t      rd_addr;
   logic                scrub_en;
   logic                rd_valid;
   ecc_pkg::data_t      rd_data;
   logic                rd_single_err;
   logic                rd_double_err;
   ecc_pkg::fix_count_t scrub_fix_count;

   entry_t         stim_q[$];
   ecc_pkg::data_t rnd[10];
   integer         seed;
   int             errors;
   int             checks;
   int             cycles;

   ecc_store_top dut_i (
      .clk             (clk),
      .rst_l           (rst_l),
      .wr_en           (wr_en),
      .wr_addr         (wr_addr),
      .wr_data         (wr_data),
      .inj_mask        (inj_mask),
      .rd_en           (rd_en),
      .rd_addr         (rd_addr),
      .scrub_en        (scrub_en),
      .rd_valid        (rd_valid),
      .rd_data         (rd_data),
      .rd_single_err   (rd_single_err),
      .rd_double_err   (rd_double_err),
      .scrub_fix_count (scrub_fix_count)
   );

   always #50 clk = ~clk;   // 100 ns period

   function automatic ecc_pkg::code_t bit_mask(input int b);
      ecc_pkg::code_t m;
      m    = '0;
      m[b] = 1'b1;
      return m;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // wait until the scrubber busy level matches, at most limit cycles
   task automatic wait_busy(input logic level, input int limit, input string what);
      int n;
      n = 0;
      while (dut_i.scrub_busy !== level && n < limit) begin
         @(posedge clk);
         #DRIVE_DLY;
         n++;
      end
      if (dut_i.scrub_busy !== level) begin
         errors++;
         $display("Timeout: %s", what);
      end
   endtask

   task automatic add_entry(input op_t op, input ecc_pkg::addr_t addr,
                            input ecc_pkg::data_t data, input ecc_pkg::code_t mask,
                            input ecc_pkg::data_t exp_data, input logic exp_single,
                            input logic exp_double);
      entry_t e;
      e = '{op, addr, data, mask, exp_data, exp_single, exp_double};
      stim_q.push_back(e);
   endtask

   // write, then read back; double errors return the raw data bits
   task automatic build_table();
      ecc_pkg::code_t m1;
      ecc_pkg::code_t m2;
      m1 = bit_mask(7) | bit_mask(20);
      m2 = bit_mask(3) | bit_mask(34);   // one data bit, one check bit
      add_entry(op_write, 4'd0, rnd[0], '0, '0, 1'b0, 1'b0);
      add_entry(op_read, 4'd0, '0, '0, rnd[0], 1'b0, 1'b0);
      add_entry(op_write, 4'd1, rnd[1], bit_mask(5), '0, 1'b0, 1'b0);
      add_entry(op_read, 4'd1, '0, '0, rnd[1], 1'b1, 1'b0);
      add_entry(op_write, 4'd2, rnd[2], bit_mask(35), '0, 1'b0, 1'b0);
      add_entry(op_read, 4'd2, '0, '0, rnd[2], 1'b1, 1'b0);
      add_entry(op_write, 4'd3, rnd[3], bit_mask(38), '0, 1'b0, 1'b0);   // overall parity
      add_entry(op_read, 4'd3, '0, '0, rnd[3], 1'b1, 1'b0);
      add_entry(op_write, 4'd4, rnd[4], m1, '0, 1'b0, 1'b0);
      add_entry(op_read, 4'd4, '0, '0, rnd[4] ^ m1[31:0], 1'b0, 1'b1);
      add_entry(op_write, 4'd5, rnd[5], m2, '0, 1'b0, 1'b0);
      add_entry(op_read, 4'd5, '0, '0, rnd[5] ^ m2[31:0], 1'b0, 1'b1);
      // read and write to one address in the same cycle return the old word
      add_entry(op_rdwr, 4'd0, rnd[6], '0, rnd[0], 1'b0, 1'b0);
      add_entry(op_read, 4'd0, '0, '0, rnd[6], 1'b0, 1'b0);
   endtask

   // drive one entry, then check the read one cycle later
   task automatic apply_entry(input entry_t e);
      @(posedge clk);
      #DRIVE_DLY;
      if (e.op != op_read) begin
         wr_en    = 1'b1;
         wr_addr  = e.addr;
         wr_data  = e.data;
         inj_mask = e.mask;
      end
      if (e.op != op_write) begin
         rd_en   = 1'b1;
         rd_addr = e.addr;
      end
      @(posedge clk);
      #DRIVE_DLY;
      wr_en    = 1'b0;
      rd_en    = 1'b0;
      inj_mask = '0;
      if (e.op != op_write) begin
         check_value("rd_valid", 64'(rd_valid), 64'd1);
         check_value("rd_data", 64'(rd_data), 64'(e.exp_data));
         check_value("rd_single_err", 64'(rd_single_err), 64'(e.exp_single));
         check_value("rd_double_err", 64'(rd_double_err), 64'(e.exp_double));
      end
   endtask

   initial begin
      entry_t         e;
      ecc_pkg::code_t dbl_mask;
      clk      = 1'b0;
      rst_l    = 1'b0;
      wr_en    = 1'b0;
      wr_addr  = '0;
      wr_data  = '0;
      inj_mask = '0;
      rd_en    = 1'b0;
      rd_addr  = '0;
      scrub_en = 1'b0;
      errors   = 0;
      checks   = 0;
      seed     = 32'haa688974;
      for (int i = 0; i < 10; i++) begin
         rnd[i] = $random(seed);
      end
      repeat (16) @(posedge clk);
      #DRIVE_DLY;
      rst_l = 1'b1;

      // every word reads as a clean zero after reset
      for (int i = 0; i < ecc_pkg::DEPTH; i++) begin
         e = '{op_read, ecc_pkg::addr_t'(i), '0, '0, '0, 1'b0, 1'b0};
         apply_entry(e);
      end
      check_value("scrub_fix_count", 64'(scrub_fix_count), 64'd0);

      build_table();
      foreach (stim_q[i]) begin
         apply_entry(stim_q[i]);
      end

      // three single errors for the scrubber to repair, one double it must leave
      dbl_mask = bit_mask(12) | bit_mask(13);
      e = '{op_write, 4'd1, rnd[7], bit_mask(9), '0, 1'b0, 1'b0};
      apply_entry(e);
      e = '{op_write, 4'd2, rnd[8], bit_mask(33), '0, 1'b0, 1'b0};
      apply_entry(e);
      e = '{op_write, 4'd3, rnd[9], bit_mask(30), '0, 1'b0, 1'b0};
      apply_entry(e);
      e = '{op_write, 4'd4, rnd[6], dbl_mask, '0, 1'b0, 1'b0};
      apply_entry(e);

      @(posedge clk);
      #DRIVE_DLY;
      scrub_en = 1'b1;
      cycles   = 0;
      while (scrub_fix_count != 8'd3 && cycles < SCRUB_TIMEOUT) begin
         @(posedge clk);
         #DRIVE_DLY;
         cycles++;
      end
      if (scrub_fix_count != 8'd3) begin
         errors++;
         $display("Timeout: scrub_fix_count did not reach 3 within %0d cycles",
                  SCRUB_TIMEOUT);
      end
      scrub_en = 1'b0;
      wait_busy(1'b0, BUSY_TIMEOUT,
                "scrub pass did not finish after the enable was lowered");

      e = '{op_read, 4'd1, '0, '0, rnd[7], 1'b0, 1'b0};
      apply_entry(e);
      e = '{op_read, 4'd2, '0, '0, rnd[8], 1'b0, 1'b0};
      apply_entry(e);
      e = '{op_read, 4'd3, '0, '0, rnd[9], 1'b0, 1'b0};
      apply_entry(e);
      e = '{op_read, 4'd4, '0, '0, rnd[6] ^ dbl_mask[31:0], 1'b0, 1'b1};
      apply_entry(e);

      // another full pass over the repaired store finds nothing to fix
      scrub_en = 1'b1;
      wait_busy(1'b1, SCRUB_TIMEOUT, "second scrub pass did not start");
      wait_busy(1'b0, BUSY_TIMEOUT, "second scrub pass did not finish");
      scrub_en = 1'b0;
      check_value("scrub_fix_count", 64'(scrub_fix_count), 64'd3);
      e = '{op_read, 4'd4, '0, '0, rnd[6] ^ dbl_mask[31:0], 1'b0, 1'b1};
      apply_entry(e);

      $display("checks run %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: ecc_store.f
hw/ecc_pkg.sv
hw/secded_encode.sv
hw/secded_decode.sv
hw/ecc_word_array.sv
hw/scrub_timer.sv
hw/scrub_fsm.sv
hw/ecc_store_top.sv
bench/ecc_store_sva.sv
bench/ecc_store_tb.sv

// File: hw/ecc_pkg.sv
// ECC store shared definitions

package ecc_pkg;

   localparam int DATA_W         = 32;
   localparam int ECC_W          = 7;
   localparam int CODE_W         = DATA_W + ECC_W;
   localparam int DEPTH          = 16;
   localparam int ADDR_W         = $clog2(DEPTH);
   localparam int SCRUB_INTERVAL = 64;   // enabled cycles between passes
   localparam int TIMER_W        = 7;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ECC_W-1:0]  ecc_t;

   // data in [31:0], check bits in [38:32]
   typedef logic [CODE_W-1:0] code_t;

   typedef logic [ADDR_W-1:0] addr_t;

   // saturates at all ones
   typedef logic [7:0]        fix_count_t;

   typedef enum logic [1:0] {
      scrub_idle,
      scrub_scan,
      scrub_fix
   } scrub_state_t;

endpackage

// File: hw/ecc_store_top.sv
// ECC protected store top level

`timescale 1ns/1ps

module ecc_store_top (
   input  logic                clk,
   input  logic                rst_l,
   input  logic                wr_en,
   input  ecc_pkg::addr_t      wr_addr,
   input  ecc_pkg::data_t      wr_data,
   input  ecc_pkg::code_t      inj_mask,
   input  logic                rd_en,
   input  ecc_pkg::addr_t      rd_addr,
   input  logic                scrub_en,
   output logic                rd_valid,
   output ecc_pkg::data_t      rd_data,
   output logic                rd_single_err,
   output logic                rd_double_err,
   output ecc_pkg::fix_count_t scrub_fix_count
);

   ecc_pkg::ecc_t  wr_ecc;
   ecc_pkg::ecc_t  fix_ecc;
   ecc_pkg::code_t rd_code;
   ecc_pkg::code_t scan_code;
   ecc_pkg::data_t scan_data;      // corrected word under the scrubber
   ecc_pkg::addr_t scrub_addr;
   logic           scan_single_err;
   logic           scrub_wr;
   logic           scrub_busy;
   logic           scrub_start;

   secded_encode wr_enc (
      .data (wr_data),
      .ecc  (wr_ecc)
   );

   // rebuilds a clean codeword from the corrected scrub data
   secded_encode fix_enc (
      .data (scan_data),
      .ecc  (fix_ecc)
   );

   ecc_word_array array_i (
      .clk        (clk),
      .rst_l      (rst_l),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_code    ({wr_ecc, wr_data}),
      .inj_mask   (inj_mask),
      .scrub_wr   (scrub_wr),
      .scrub_addr (scrub_addr),
      .scrub_code ({fix_ecc, scan_data}),
      .rd_en      (rd_en),
      .rd_addr    (rd_addr),
      .rd_code    (rd_code),
      .rd_valid   (rd_valid),
      .scan_code  (scan_code)
   );

   secded_decode rd_dec (
      .code       (rd_code),
      .data       (rd_data),
      .single_err (rd_single_err),
      .double_err (rd_double_err)
   );

   // double errors are left alone by the scrubber
   secded_decode scan_dec (
      .code       (scan_code),
      .data       (scan_data),
      .single_err (scan_single_err),
      .double_err ()
   );

   scrub_timer timer_i (
      .clk         (clk),
      .rst_l       (rst_l),
      .scrub_en    (scrub_en),
      .scrub_busy  (scrub_busy),
      .scrub_start (scrub_start)
   );

   scrub_fsm fsm_i (
      .clk             (clk),
      .rst_l           (rst_l),
      .scrub_start     (scrub_start),
      .wr_en           (wr_en),
      .wr_addr         (wr_addr),
      .scan_single_err (scan_single_err),
      .scrub_addr      (scrub_addr),
      .scrub_wr        (scrub_wr),
      .scrub_busy      (scrub_busy),
      .fix_count       (scrub_fix_count)
   );

endmodule

// File: hw/ecc_word_array.sv
// ECC codeword storage

`timescale 1ns/1ps

module ecc_word_array (
   input  logic           clk,
   input  logic           rst_l,
   input  logic           wr_en,
   input  ecc_pkg::addr_t wr_addr,
   input  ecc_pkg::code_t wr_code,
   input  ecc_pkg::code_t inj_mask,
   input  logic           scrub_wr,
   input  ecc_pkg::addr_t scrub_addr,
   input  ecc_pkg::code_t scrub_code,
   input  logic           rd_en,
   input  ecc_pkg::addr_t rd_addr,
   output ecc_pkg::code_t rd_code,
   output logic           rd_valid,
   output ecc_pkg::code_t scan_code
);

   ecc_pkg::code_t mem [ecc_pkg::DEPTH];

   // all zero is a valid codeword, so reset leaves a clean store
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         for (int i = 0; i < ecc_pkg::DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_en) begin
         mem[wr_addr] <= wr_code ^ inj_mask;   // debug flips on user writes only
      end else if (scrub_wr) begin
         mem[scrub_addr] <= scrub_code;
      end
   end

   // old word on a same-address write
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rd_valid <= 1'b0;
         rd_code  <= '0;
      end else begin
         rd_valid <= rd_en;
         if (rd_en) begin
            rd_code <= mem[rd_addr];
         end
      end
   end

   assign scan_code = mem[scrub_addr];   // scrubber looks at the word in the same cycle

endmodule

// File: hw/scrub_fsm.sv
// Scrub pass state machine

`timescale 1ns/1ps

module scrub_fsm (
   input  logic                clk,
   input  logic                rst_l,
   input  logic                scrub_start,
   input  logic                wr_en,
   input  ecc_pkg::addr_t      wr_addr,
   input  logic                scan_single_err,
   output ecc_pkg::addr_t      scrub_addr,
   output logic                scrub_wr,
   output logic                scrub_busy,
   output ecc_pkg::fix_count_t fix_count
);

   ecc_pkg::scrub_state_t state;
   ecc_pkg::addr_t        addr;
   logic                  last_addr;
   logic                  user_hit;

   assign last_addr = (addr == ecc_pkg::addr_t'(ecc_pkg::DEPTH - 1));
   assign user_hit  = wr_en && (wr_addr == addr);   // user owns this word now

   // user writes always win the port
   // skip the write if the word no longer holds a single error
   assign scrub_wr   = (state == ecc_pkg::scrub_fix) && !wr_en && scan_single_err;
   assign scrub_busy = (state != ecc_pkg::scrub_idle);
   assign scrub_addr = addr;

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         state <= ecc_pkg::scrub_idle;
         addr  <= '0;
      end else begin
         case (state)
            ecc_pkg::scrub_idle: begin
               if (scrub_start) begin
                  state <= ecc_pkg::scrub_scan;
                  addr  <= '0;
               end
            end
            ecc_pkg::scrub_scan: begin
               if (scan_single_err) begin
                  state <= ecc_pkg::scrub_fix;   // hold addr for the write-back
               end else if (last_addr) begin
                  state <= ecc_pkg::scrub_idle;
               end else begin
                  addr <= addr + 1'b1;
               end
            end
            ecc_pkg::scrub_fix: begin
               // written, dropped, or wait while a user write goes elsewhere
               if (!wr_en || user_hit) begin
                  if (last_addr) begin
                     state <= ecc_pkg::scrub_idle;
                  end else begin
                     state <= ecc_pkg::scrub_scan;
                     addr  <= addr + 1'b1;
                  end
               end
            end
            default: state <= ecc_pkg::scrub_idle;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         fix_count <= '0;
      end else if (scrub_wr && (fix_count != '1)) begin
         fix_count <= fix_count + 1'b1;   // saturating
      end
   end

endmodule

// File: hw/scrub_timer.sv
// Scrub interval timer

`timescale 1ns/1ps

module scrub_timer (
   input  logic clk,
   input  logic rst_l,
   input  logic scrub_en,
   input  logic scrub_busy,
   output logic scrub_start
);

   logic                       en_ff1;
   logic                       en_sync;
   logic [ecc_pkg::TIMER_W-1:0] count;

   // two-flop synchronizer for the asynchronous enable level
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         en_ff1  <= 1'b0;
         en_sync <= 1'b0;
      end else begin
         en_ff1  <= scrub_en;
         en_sync <= en_ff1;
      end
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         count       <= '0;
         scrub_start <= 1'b0;
      end else begin
         scrub_start <= 1'b0;
         if (!en_sync) begin
            count <= '0;                      // disabled, restart the interval
         end else if (!scrub_busy) begin      // held while a pass runs
            if (count == ecc_pkg::SCRUB_INTERVAL) begin
               count       <= '0;
               scrub_start <= 1'b1;
            end else begin
               count <= count + 1'b1;
            end
         end
      end
   end

endmodule

// File: hw/secded_decode.sv
// SECDED syndrome check and correction

`timescale 1ns/1ps

module secded_decode (
   input  ecc_pkg::code_t code,
   output ecc_pkg::data_t data,
   output logic           single_err,
   output logic           double_err
);

   logic [ecc_pkg::CODE_W:1]  ham;      // codeword in hamming order
   logic [ecc_pkg::CODE_W:1]  fixed;
   logic [ecc_pkg::ECC_W-2:0] syn;
   logic                      parity_fail;

   // position 39 is the overall parity bit, outside the syndrome space
   assign ham = {code[38], code[31:26], code[37], code[25:11], code[36], code[10:4],
                 code[35], code[3:1], code[34], code[0], code[33:32]};

   // syndrome includes the stored check bits at their own positions
   always_comb begin
      syn = '0;
      for (int k = 0; k < ecc_pkg::ECC_W - 1; k++) begin
         for (int p = 1; p < ecc_pkg::CODE_W; p++) begin
            if (p[k]) begin
               syn[k] = syn[k] ^ ham[p];
            end
         end
      end
   end

   assign parity_fail = ^ham;

   // odd number of flips counts as single, even and nonzero as double
   assign single_err = parity_fail;
   assign double_err = (syn != '0) && !parity_fail;

   always_comb begin
      fixed = ham;
      if (single_err) begin
         if (syn == '0) begin
            fixed[ecc_pkg::CODE_W] = ~ham[ecc_pkg::CODE_W];   // parity bit itself
         end else if (syn < ecc_pkg::CODE_W) begin
            fixed[syn] = ~ham[syn];
         end
      end
   end

   // pull the data positions back out, raw on a double error
   assign data = {fixed[38:33], fixed[31:17], fixed[15:9], fixed[7:5], fixed[3]};

endmodule

// File: hw/secded_encode.sv
// SECDED check bit generator

`timescale 1ns/1ps

module secded_encode (
   input  ecc_pkg::data_t data,
   output ecc_pkg::ecc_t  ecc
);

   // hamming positions 38..1, check slots (powers of two) held at zero
   logic [ecc_pkg::CODE_W-1:1] spread;
   logic [ecc_pkg::ECC_W-2:0]  chk;

   assign spread = {data[31:26], 1'b0, data[25:11], 1'b0, data[10:4], 1'b0,
                    data[3:1], 1'b0, data[0], 2'b00};

   // check bit k covers every position whose index has bit k set
   always_comb begin
      chk = '0;
      for (int k = 0; k < ecc_pkg::ECC_W - 1; k++) begin
         for (int p = 1; p < ecc_pkg::CODE_W; p++) begin
            if (p[k]) begin
               chk[k] = chk[k] ^ spread[p];
            end
         end
      end
   end

   // overall parity over data and the six hamming bits
   assign ecc = {(^data) ^ (^chk), chk};

endmodule

// File: run_sim.sh
#!/bin/sh
# build the ECC store testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module ecc_store_tb -f ecc_store.f -o ecc_store_sim \
   && ./obj_dir/ecc_store_sim | tee /dev/stderr \
      | grep -q "Simulation completed successfully" \
   && echo "RESULT: PASS" \
   || { echo "RESULT: FAIL"; exit 1; }
